/* source/dvi_timing_pkg.sv */
package dvi_timing_pkg;

    typedef logic [1:0] chip_t;   // bit 0 set means PAL
    typedef logic [9:0] hcount_t; // output column
    typedef logic [9:0] vcount_t; // output row

    localparam chip_t chip_6567r8   = 2'd0;
    localparam chip_t chip_6569r3   = 2'd1;
    localparam chip_t chip_6567r56a = 2'd2;
    localparam chip_t chip_6569r1   = 2'd3;

    // ----------------------------------------------------------------------
    // per-chip timing, boundaries in native units (scaled in timing_select)
    // ----------------------------------------------------------------------
    typedef struct packed {
        hcount_t max_width;      // last output column, already in dvi units
        vcount_t max_height_nat; // last row, native vertical scan
        vcount_t max_height_dbl; // last row, doubled vertical scan
        hcount_t x_offset;       // added to h_count for the line-buffer read
        hcount_t ha_end;
        hcount_t hs_sta;
        hcount_t hs_end;
        hcount_t ha_sta;
        vcount_t va_end;         // PAL: really active start, blanking crosses row 0
        vcount_t vs_sta;
        vcount_t vs_end;
        vcount_t va_sta;         // PAL: really active end
    } timing_set_t;

    localparam timing_set_t timing_6567r8 = '{
        10'd844, 10'd262, 10'd525, 10'd142,
        10'd0, 10'd5, 10'd35, 10'd40, 10'd11, 10'd19, 10'd23, 10'd27};
    localparam timing_set_t timing_6567r56a = '{
        10'd831, 10'd261, 10'd523, 10'd146,
        10'd0, 10'd5, 10'd35, 10'd40, 10'd11, 10'd19, 10'd23, 10'd27};
    localparam timing_set_t timing_pal = '{
        10'd944, 10'd311, 10'd623, 10'd32,
        10'd0, 10'd10, 10'd70, 10'd90, 10'd20, 10'd289, 10'd291, 10'd284};

    // true from (v_from, h_from) up to but not including (v_to, h_to)
    function automatic logic raster_window(hcount_t h, vcount_t v, vcount_t v_from,
                                           hcount_t h_from, vcount_t v_to, hcount_t h_to);
        raster_window = ((v == v_from && h >= h_from) || v > v_from) &&
                        ((v == v_to && h < h_to) || v < v_to);
    endfunction

endpackage

/* source/pixel_pkg.sv */
package pixel_pkg;

    typedef logic [3:0] color_t;     // palette index
    typedef logic [9:0] line_addr_t; // line-buffer address

    localparam int line_depth = 1024; // covers the widest read, 944 + offset

    // native raster position that comes with each pixel
    typedef logic [9:0] raster_x_t;
    typedef logic [8:0] raster_y_t;

endpackage

/* source/line_ram.sv */
`timescale 1ns/10ps

// one raster line of colours, write port and registered read port
module line_ram (
    input  logic                  clk_dvi,
    input  logic                  we,
    input  pixel_pkg::line_addr_t wr_addr,
    input  pixel_pkg::color_t     wr_data,
    input  pixel_pkg::line_addr_t rd_addr,
    output pixel_pkg::color_t     rd_data
);

    pixel_pkg::color_t mem [pixel_pkg::line_depth];

    always_ff @(posedge clk_dvi) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr]; // one cycle read latency
    end

endmodule

/* source/line_buffer.sv */
`timescale 1ns/10ps

// double line buffer: one bank fills from the pixel strobe while the other
// is read back at the dvi scan position, so output runs one line behind
module line_buffer (
    input  logic                  clk_dvi,
    input  logic                  rst,
    input  logic                  pixel_strobe,
    input  pixel_pkg::raster_x_t  raster_x,
    input  pixel_pkg::raster_y_t  raster_y,
    input  pixel_pkg::color_t     pixel_color,
    input  pixel_pkg::line_addr_t read_addr,
    output logic                  frame_strobe,
    output pixel_pkg::color_t     pixel_out
);

    logic              bank;      // write bank, read from the other one
    logic              bank_next;
    logic              bank_q;    // bank delayed to match ram latency
    logic              read_live; // low right after reset, ram data not valid yet
    logic              line_start;
    pixel_pkg::color_t dout0;
    pixel_pkg::color_t dout1;

    assign line_start = pixel_strobe && raster_x == '0;
    assign bank_next  = line_start ? ~bank : bank; // swap before the first pixel lands

    line_ram u_ram0 (
        .clk_dvi (clk_dvi),
        .we      (pixel_strobe && !bank_next),
        .wr_addr (raster_x),
        .wr_data (pixel_color),
        .rd_addr (read_addr),
        .rd_data (dout0)
    );

    line_ram u_ram1 (
        .clk_dvi (clk_dvi),
        .we      (pixel_strobe && bank_next),
        .wr_addr (raster_x),
        .wr_data (pixel_color),
        .rd_addr (read_addr),
        .rd_data (dout1)
    );

    // ----------------------------------------------------------------------
    // bank control, frame detect and output register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_dvi) begin
        if (rst) begin
            bank         <= 1'b0;
            bank_q       <= 1'b0;
            read_live    <= 1'b0;
            frame_strobe <= 1'b0;
            pixel_out    <= '0;
        end else begin
            bank         <= bank_next;
            bank_q       <= bank;                              // lines up with rd_data
            read_live    <= 1'b1;
            frame_strobe <= line_start && raster_y == '0;      // raster (0,0)
            if (read_live) begin
                pixel_out <= bank_q ? dout0 : dout1;           // not the write bank
            end
        end
    end

endmodule

/* source/timing_select.sv */
`timescale 1ns/10ps

// timing set for the chip, scaled for the scan mode; mode changes take
// effect only at a frame start
module timing_select (
    input  logic                    clk_dvi,
    input  logic                    rst,
    input  logic                    frame_strobe,
    input  dvi_timing_pkg::chip_t   chip,
    input  logic                    native_y,
    output dvi_timing_pkg::hcount_t hs_sta,
    output dvi_timing_pkg::hcount_t hs_end,
    output dvi_timing_pkg::hcount_t ha_sta,
    output dvi_timing_pkg::hcount_t ha_end,
    output dvi_timing_pkg::vcount_t vs_sta,
    output dvi_timing_pkg::vcount_t vs_end,
    output dvi_timing_pkg::vcount_t va_sta,
    output dvi_timing_pkg::vcount_t va_end,
    output dvi_timing_pkg::hcount_t max_width,
    output dvi_timing_pkg::vcount_t max_height,
    output pixel_pkg::line_addr_t   x_offset,
    output logic                    native_y_used,
    output logic                    pal
);

    dvi_timing_pkg::chip_t       chip_q; // latched mode
    dvi_timing_pkg::timing_set_t set_sel;
    logic                        mode_change;

    always_comb begin
        case (chip)
            dvi_timing_pkg::chip_6567r8:   set_sel = dvi_timing_pkg::timing_6567r8;
            dvi_timing_pkg::chip_6567r56a: set_sel = dvi_timing_pkg::timing_6567r56a;
            default:                       set_sel = dvi_timing_pkg::timing_pal; // both 6569
        endcase
    end

    assign mode_change = frame_strobe && (chip != chip_q || native_y != native_y_used);
    assign pal         = chip_q[0];

    // ----------------------------------------------------------------------
    // load in reset, reload on a changed mode at frame start
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_dvi) begin
        if (rst || mode_change) begin
            chip_q        <= chip;
            native_y_used <= native_y;
            max_width     <= set_sel.max_width;
            x_offset      <= set_sel.x_offset;
            // horizontal always doubled
            ha_end <= {set_sel.ha_end[8:0], 1'b0};
            hs_sta <= {set_sel.hs_sta[8:0], 1'b0};
            hs_end <= {set_sel.hs_end[8:0], 1'b0};
            ha_sta <= {set_sel.ha_sta[8:0], 1'b0};
            if (native_y) begin
                max_height <= set_sel.max_height_nat;
                va_end     <= set_sel.va_end;
                vs_sta     <= set_sel.vs_sta;
                vs_end     <= set_sel.vs_end;
                va_sta     <= set_sel.va_sta;
            end else begin
                max_height <= set_sel.max_height_dbl;
                va_end     <= {set_sel.va_end[8:0], 1'b0}; // each native line shown twice
                vs_sta     <= {set_sel.vs_sta[8:0], 1'b0};
                vs_end     <= {set_sel.vs_end[8:0], 1'b0};
                va_sta     <= {set_sel.va_sta[8:0], 1'b0};
            end
        end
    end

endmodule

/* source/scan_counter.sv */
`timescale 1ns/10ps

// output raster counters, advance divider, frame resync and half-bright
module scan_counter (
    input  logic                    clk_dvi,
    input  logic                    rst,
    input  logic                    frame_strobe,
    input  logic                    native_y_used,
    input  dvi_timing_pkg::hcount_t max_width,
    input  dvi_timing_pkg::vcount_t max_height,
    input  pixel_pkg::line_addr_t   x_offset,
    input  dvi_timing_pkg::vcount_t va_sta,
    input  dvi_timing_pkg::vcount_t va_end,
    input  dvi_timing_pkg::hcount_t ha_sta,
    input  dvi_timing_pkg::hcount_t ha_end,
    input  logic                    pal,
    output dvi_timing_pkg::hcount_t h_count,
    output dvi_timing_pkg::vcount_t v_count,
    output pixel_pkg::line_addr_t   read_addr,
    output logic                    half_bright_raw
);

    logic [1:0] ff;       // advance divider
    logic       advance;
    logic       vactive;
    logic       v_region; // inside the vertical active rows

    // native scan advances on odd divider states, so each line takes twice as long
    assign advance   = !native_y_used || ff[0];
    assign vactive   = dvi_timing_pkg::raster_window(h_count, v_count, va_end, ha_end,
                                                     va_sta, ha_sta);
    assign v_region  = pal ? vactive : !vactive; // PAL window crosses row 0
    assign read_addr = h_count + x_offset;       // skip the unseen left border

    always_ff @(posedge clk_dvi) begin
        if (rst) begin
            ff              <= 2'b01;
            h_count         <= '0;
            v_count         <= '0;
            half_bright_raw <= 1'b0;
        end else begin
            ff <= ff + 2'd1;
            if (advance) begin
                if (h_count < max_width) begin
                    h_count <= h_count + 10'd1;
                end else begin
                    h_count <= '0;
                    if (v_count < max_height) begin
                        v_count <= v_count + 10'd1;
                    end else begin
                        v_count <= '0;
                    end
                    // alternate lines dimmed, cleared in blanking
                    half_bright_raw <= v_region ? ~half_bright_raw : 1'b0;
                end
            end
            if (frame_strobe) begin
                v_count <= max_height; // next wrap starts row 0
            end
        end
    end

endmodule

/* source/video_out.sv */
`timescale 1ns/10ps

// sync and active decode, polarity and csync, two stages to meet the pixel
module video_out (
    input  logic                    clk_dvi,
    input  logic                    rst,
    input  dvi_timing_pkg::hcount_t h_count,
    input  dvi_timing_pkg::vcount_t v_count,
    input  dvi_timing_pkg::hcount_t hs_sta,
    input  dvi_timing_pkg::hcount_t hs_end,
    input  dvi_timing_pkg::hcount_t ha_sta,
    input  dvi_timing_pkg::hcount_t ha_end,
    input  dvi_timing_pkg::vcount_t vs_sta,
    input  dvi_timing_pkg::vcount_t vs_end,
    input  dvi_timing_pkg::vcount_t va_sta,
    input  dvi_timing_pkg::vcount_t va_end,
    input  logic                    pal,
    input  logic                    half_bright_raw,
    input  logic                    hpolarity,
    input  logic                    vpolarity,
    input  logic                    enable_csync,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    active,
    output logic                    half_bright
);

    logic       hsync_ah;
    logic       vsync_ah;
    logic       csync_ah;
    logic       vactive;
    logic       active_now;
    logic       hsync_sel;
    logic       vsync_sel;
    logic [3:0] stage1;   // {hsync, vsync, active, half_bright}
    logic [3:0] stage2;

    assign hsync_ah = h_count >= hs_sta && h_count <= hs_end;
    // vsync begins and ends at the hsync column, not at column 0
    assign vsync_ah = dvi_timing_pkg::raster_window(h_count, v_count, vs_sta, hs_sta,
                                                    vs_end, hs_end);
    assign csync_ah = hsync_ah || vsync_ah;

    assign vactive    = dvi_timing_pkg::raster_window(h_count, v_count, va_end, ha_end,
                                                      va_sta, ha_sta);
    assign active_now = !((h_count >= ha_end && h_count <= ha_sta) ||
                          (pal ? !vactive : vactive));

    // polarity bit 0 means active low
    assign hsync_sel = enable_csync ? (csync_ah ~^ hpolarity) : (hsync_ah ~^ hpolarity);
    assign vsync_sel = enable_csync ? 1'b0 : (vsync_ah ~^ vpolarity);

    // ----------------------------------------------------------------------
    // delay to the ram read plus the colour register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_dvi) begin
        if (rst) begin
            stage1 <= '0;
            stage2 <= '0;
        end else begin
            stage1 <= {hsync_sel, vsync_sel, active_now, half_bright_raw};
            stage2 <= stage1;
        end
    end

    assign hsync       = stage2[3];
    assign vsync       = stage2[2];
    assign active      = stage2[1];
    assign half_bright = stage2[0];

endmodule

/* source/line_doubler_top.sv */
`timescale 1ns/10ps

module line_doubler_top (
    input  logic                  clk_dvi,
    input  logic                  rst,
    input  dvi_timing_pkg::chip_t chip,
    input  logic                  native_y,
    input  logic                  hpolarity,
    input  logic                  vpolarity,
    input  logic                  enable_csync,
    input  logic                  pixel_strobe,
    input  pixel_pkg::raster_x_t  raster_x,
    input  pixel_pkg::raster_y_t  raster_y,
    input  pixel_pkg::color_t     pixel_color,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  active,
    output logic                  half_bright,
    output pixel_pkg::color_t     pixel_color_out
);

    logic                    frame_strobe;
    logic                    native_y_used;
    logic                    pal;
    logic                    half_bright_raw;
    pixel_pkg::line_addr_t   read_addr;
    pixel_pkg::line_addr_t   x_offset;
    dvi_timing_pkg::hcount_t h_count, max_width;
    dvi_timing_pkg::vcount_t v_count, max_height;
    dvi_timing_pkg::hcount_t hs_sta, hs_end, ha_sta, ha_end;
    dvi_timing_pkg::vcount_t vs_sta, vs_end, va_sta, va_end;

    line_buffer u_line_buffer (
        .clk_dvi      (clk_dvi),
        .rst          (rst),
        .pixel_strobe (pixel_strobe),
        .raster_x     (raster_x),
        .raster_y     (raster_y),
        .pixel_color  (pixel_color),
        .read_addr    (read_addr),
        .frame_strobe (frame_strobe),
        .pixel_out    (pixel_color_out)
    );

    timing_select u_timing_select (
        .clk_dvi       (clk_dvi),
        .rst           (rst),
        .frame_strobe  (frame_strobe),
        .chip          (chip),
        .native_y      (native_y),
        .hs_sta        (hs_sta),
        .hs_end        (hs_end),
        .ha_sta        (ha_sta),
        .ha_end        (ha_end),
        .vs_sta        (vs_sta),
        .vs_end        (vs_end),
        .va_sta        (va_sta),
        .va_end        (va_end),
        .max_width     (max_width),
        .max_height    (max_height),
        .x_offset      (x_offset),
        .native_y_used (native_y_used),
        .pal           (pal)
    );

    scan_counter u_scan_counter (
        .clk_dvi         (clk_dvi),
        .rst             (rst),
        .frame_strobe    (frame_strobe),
        .native_y_used   (native_y_used),
        .max_width       (max_width),
        .max_height      (max_height),
        .x_offset        (x_offset),
        .va_sta          (va_sta),
        .va_end          (va_end),
        .ha_sta          (ha_sta),
        .ha_end          (ha_end),
        .pal             (pal),
        .h_count         (h_count),
        .v_count         (v_count),
        .read_addr       (read_addr),
        .half_bright_raw (half_bright_raw)
    );

    video_out u_video_out (
        .clk_dvi         (clk_dvi),
        .rst             (rst),
        .h_count         (h_count),
        .v_count         (v_count),
        .hs_sta          (hs_sta),
        .hs_end          (hs_end),
        .ha_sta          (ha_sta),
        .ha_end          (ha_end),
        .vs_sta          (vs_sta),
        .vs_end          (vs_end),
        .va_sta          (va_sta),
        .va_end          (va_end),
        .pal             (pal),
        .half_bright_raw (half_bright_raw),
        .hpolarity       (hpolarity),
        .vpolarity       (vpolarity),
        .enable_csync    (enable_csync),
        .hsync           (hsync),
        .vsync           (vsync),
        .active          (active),
        .half_bright     (half_bright)
    );

endmodule

/* testbench/line_doubler_chk.sv */
`timescale 1ns/10ps

// protocol checks on the top level outputs
module line_doubler_chk (
    input logic clk_dvi,
    input logic rst,
    input logic enable_csync,
    input logic hpolarity,
    input logic hsync,
    input logic vsync,
    input logic active,
    input logic half_bright
);

    // csync mode holds vsync low once the change has passed the two output stages
    a_csync_vsync_low : assert property (@(posedge clk_dvi) disable iff (rst)
        (enable_csync && $past(enable_csync) && $past(enable_csync, 2)) |-> !vsync)
        else $error("vsync high while csync is enabled");

    // hsync lies inside horizontal blanking for every chip
    a_no_active_in_sync : assert property (@(posedge clk_dvi) disable iff (rst)
        (hpolarity == $past(hpolarity) && hpolarity == $past(hpolarity, 2))
        |-> !(active && hsync == hpolarity))
        else $error("active high during hsync");

    // output pipeline still flushed right after reset
    a_quiet_after_reset : assert property (@(posedge clk_dvi)
        $fell(rst) |-> (!active && !half_bright) ##1 (!active && !half_bright))
        else $error("active or half_bright high just after reset");

endmodule

bind line_doubler_top line_doubler_chk u_chk (
    .clk_dvi      (clk_dvi),
    .rst          (rst),
    .enable_csync (enable_csync),
    .hpolarity    (hpolarity),
    .hsync        (hsync),
    .vsync        (vsync),
    .active       (active),
    .half_bright  (half_bright)
);

/* testbench/tb_line_doubler.sv */
`timescale 1ns/10ps

module tb_line_doubler;

    logic       clk_dvi = 1'b0;
    logic       rst;
    logic [1:0] chip;
    logic       native_y, hpolarity, vpolarity, enable_csync;
    logic       pixel_strobe;
    logic [9:0] raster_x;
    logic [8:0] raster_y;
    logic [3:0] pixel_color;
    logic       hsync, vsync, active, half_bright;
    logic [3:0] pixel_color_out;
    int         errors = 0;
    int         failed_tests = 0;
    int         tests = 0;
    int         test_start;
    int         run, period, seed_val;

    line_doubler_top UUT (.*);

    always #10 clk_dvi = ~clk_dvi; // 20 ns period

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        errors++;
    endtask

    task automatic check_int(input string sig, input int got, input int exp);
        assert (got == exp) else begin
            $display("ERROR %0t %s expected %0d got %0d", $time, sig, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors != test_start) failed_tests++;
        $display("%-14s %s", name, (errors == test_start) ? "ok" : "FAILED");
        test_start = errors;
    endtask

    // drive one strobe cycle, 2 ns after the edge
    task automatic send_pixel(input logic [9:0] x, input logic [8:0] y, input logic [3:0] c);
        @(posedge clk_dvi);
        #2;
        pixel_strobe = 1'b1;
        raster_x     = x;
        raster_y     = y;
        pixel_color  = c;
        @(posedge clk_dvi);
        #2;
        pixel_strobe = 1'b0;
    endtask

    task automatic wait_hsync_edge(input logic level);
        logic prev;
        prev = hsync;
        for (int i = 0; i < 4000; i++) begin
            @(negedge clk_dvi);
            if (prev != level && hsync == level) return;
            prev = hsync;
        end
        report_timeout("an hsync edge");
    endtask

    // run length at the given level and spacing of successive edges
    task automatic measure_hsync(input logic level, output int run_len, output int spacing);
        logic prev;
        wait_hsync_edge(level);
        run_len = 0;
        while (hsync == level && run_len < 4000) begin
            run_len++;
            @(negedge clk_dvi);
        end
        if (run_len >= 4000) report_timeout("the end of hsync");
        spacing = run_len;
        prev    = hsync;
        while (!(prev != level && hsync == level) && spacing < 8000) begin
            prev = hsync;
            @(negedge clk_dvi);
            spacing++;
        end
        if (spacing >= 8000) report_timeout("the next hsync");
    endtask

    // mode change at a frame strobe, skip the line that straddles it
    task automatic change_mode(input logic [1:0] new_chip, input logic new_native);
        @(posedge clk_dvi);
        #2;
        chip     = new_chip;
        native_y = new_native;
        send_pixel(10'd0, 9'd0, 4'd0);
        measure_hsync(hpolarity, run, period);
    endtask

    initial begin
        logic [3:0] fill;
        logic       prev, prev_v, cur_hb, last_hb, last_act;
        int         edges, acts, n;
        seed_val     = $urandom(42);
        rst          = 1'b1;
        chip         = 2'd0;
        native_y     = 1'b0;
        hpolarity    = 1'b1;
        vpolarity    = 1'b1;
        enable_csync = 1'b0;
        pixel_strobe = 1'b0;
        raster_x     = '0;
        raster_y     = '0;
        pixel_color  = '0;
        test_start   = 0;
        repeat (2) @(posedge clk_dvi);
        #2 rst = 1'b0;

        // ------------------------------------------------------------------
        // line timing, doubled then native
        // ------------------------------------------------------------------
        measure_hsync(1'b1, run, period);
        check_int("hsync_run", run, 61);
        check_int("hsync_period", period, 845);
        change_mode(2'd0, 1'b1);
        measure_hsync(1'b1, run, period);
        check_int("hsync_run", run, 122);
        check_int("hsync_period", period, 1690);
        change_mode(2'd0, 1'b0);
        report_test("line_timing");

        // polarity, then csync
        @(posedge clk_dvi);
        #2;
        hpolarity = 1'b0;
        measure_hsync(1'b0, run, period);
        measure_hsync(1'b0, run, period);
        check_int("hsync_low_run", run, 61);
        @(posedge clk_dvi);
        #2;
        enable_csync = 1'b1;
        repeat (3) @(negedge clk_dvi);
        run = 0;
        n   = 0;
        while (run <= 845 && n < 900000) begin // long sync run only in vsync rows
            @(negedge clk_dvi);
            n++;
            run = (hsync == 1'b0) ? run + 1 : 0;
            check_int("vsync", vsync, 0);
        end
        if (n >= 900000) report_timeout("csync across vsync rows");
        @(posedge clk_dvi);
        #2;
        enable_csync = 1'b0;
        hpolarity    = 1'b1;
        measure_hsync(1'b1, run, period);
        report_test("polarity_csync");

        // ------------------------------------------------------------------
        // frame resync: strobe just after an hsync pulse
        // ------------------------------------------------------------------
        wait_hsync_edge(1'b0);
        send_pixel(10'd0, 9'd0, 4'd0);
        edges  = 0;
        n      = 0;
        prev   = hsync;
        prev_v = vsync;
        while (n < 50000) begin
            @(negedge clk_dvi);
            n++;
            if (!prev && hsync) edges++;
            if (!prev_v && vsync) break;
            prev   = hsync;
            prev_v = vsync;
        end
        if (n >= 50000) report_timeout("vsync after resync");
        check_int("hsync_edges_to_vsync", edges, 2 * 19 + 1);
        report_test("frame_resync");

        // pixel path: fill a line, swap banks, read it back
        fill = 4'($urandom_range(15, 1)); // nonzero, unlike the idle bank
        for (int x = 0; x < 1024; x++) begin
            @(posedge clk_dvi);
            #2;
            pixel_strobe = 1'b1;
            raster_x     = 10'(x);
            raster_y     = 9'd1;
            pixel_color  = fill;
        end
        send_pixel(10'd0, 9'd1, fill);
        wait_hsync_edge(1'b1); // start of the following line
        n = 0;
        while (!active && n < 900000) begin
            @(negedge clk_dvi);
            n++;
        end
        if (n >= 900000) report_timeout("an active line");
        n = 0;
        while (active && n < 2000) begin
            check_int("pixel_color_out", pixel_color_out, fill);
            @(negedge clk_dvi);
            n++;
        end
        if (n >= 2000) report_timeout("the end of the active line");
        report_test("pixel_path");

        // ------------------------------------------------------------------
        // half-bright over more than a full doubled frame
        // ------------------------------------------------------------------
        wait_hsync_edge(1'b1);
        cur_hb   = half_bright;
        last_hb  = 1'b0;
        last_act = 1'b0;
        for (int l = 0; l < 530; l++) begin
            acts = 0;
            n    = 0;
            prev = 1'b1;
            while (n < 2000) begin
                @(negedge clk_dvi);
                n++;
                if (active) acts++;
                if (!prev && hsync) break;
                prev = hsync;
            end
            if (n >= 2000) report_timeout("the next line");
            if (l > 0 && acts > 0 && last_act) check_int("half_bright", cur_hb, !last_hb);
            if (l > 0 && acts == 0 && !last_act) check_int("half_bright", cur_hb, 0);
            last_act = (acts > 0);
            last_hb  = cur_hb;
            cur_hb   = half_bright; // sampled at the new line's hsync edge
        end
        report_test("half_bright");

        // other chips
        change_mode(2'd1, 1'b0);
        measure_hsync(1'b1, run, period);
        check_int("hsync_period_pal", period, 945);
        change_mode(2'd2, 1'b0);
        measure_hsync(1'b1, run, period);
        check_int("hsync_period_r56a", period, 832);
        report_test("other_chips");

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* build.f */
source/dvi_timing_pkg.sv
source/pixel_pkg.sv
source/line_ram.sv
source/line_buffer.sv
source/timing_select.sv
source/scan_counter.sv
source/video_out.sv
source/line_doubler_top.sv
testbench/line_doubler_chk.sv
testbench/tb_line_doubler.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run the line doubler testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_line_doubler \
    -o sim_line_doubler \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_line_doubler | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
